// File: pong_pkg.sv
// Shared definitions for the paddle game video pipeline
// Widths, VGA frame constants and the structs carried down the pixel stream

package pong_pkg;

    localparam int COORD_W = 13;
    localparam int COLOR_W = 8;

    typedef logic [COORD_W-1:0] coord_t;

    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
    } rgb_t;

    // ======================================================================
    // Frame geometry
    // ======================================================================
    localparam coord_t H_TOTAL      = 13'd800;
    localparam coord_t V_TOTAL      = 13'd525;
    // Sync low ranges, both ends inclusive
    localparam coord_t H_SYNC_START = 13'd2;
    localparam coord_t H_SYNC_END   = 13'd97;
    localparam coord_t V_SYNC_START = 13'd13;
    localparam coord_t V_SYNC_END   = 13'd14;
    localparam coord_t H_VIS_START  = 13'd160;
    localparam coord_t V_VIS_START  = 13'd45;
    localparam coord_t VIS_W        = 13'd640;
    localparam coord_t VIS_H        = 13'd480;

    // Registered timing of one pixel slot
    typedef struct packed {
        logic   hs_n;
        logic   vs_n;
        logic   blank_n;
        coord_t col;
        coord_t row;
    } timing_t;

    // Idle timing, syncs inactive and blanked
    localparam timing_t TIMING_IDLE = '{hs_n: 1'b1, vs_n: 1'b1, blank_n: 1'b0,
                                        col: '0, row: '0};

    // One pixel in flight
    typedef struct packed {
        timing_t tim;
        rgb_t    rgb;
        logic    mark_left;
        logic    mark_right;
    } pixel_t;

endpackage

// File: vga_timing.sv
`timescale 1ns/1ns
// VGA frame timing generator
// Counts an 800 x 525 frame and registers sync, blank and the visible
// column and row, plus a one-cycle pulse at the falling edge of vsync

module vga_timing
    import pong_pkg::*;
(
    input  logic    VGA_CLK,
    input  logic    i_rst,
    output timing_t o_timing,
    output logic    o_frame_start
);

    localparam coord_t H_LAST = H_TOTAL - 13'd1;
    localparam coord_t V_LAST = V_TOTAL - 13'd1;

    coord_t  x_cnt;
    coord_t  y_cnt;
    logic    vis;
    timing_t timing_next;

    // ======================================================================
    // Frame counters
    // ======================================================================
    always_ff @(posedge VGA_CLK) begin
        if (i_rst) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (x_cnt == H_LAST) begin
            x_cnt <= '0;
            if (y_cnt == V_LAST) begin
                y_cnt <= '0;
            end else begin
                y_cnt <= y_cnt + 13'd1;
            end
        end else begin
            x_cnt <= x_cnt + 13'd1;
        end
    end

    // ======================================================================
    // Sync, blank and visible coordinates
    // ======================================================================
    always_comb begin
        vis = (x_cnt >= H_VIS_START) && (y_cnt >= V_VIS_START);

        timing_next.hs_n    = !((x_cnt >= H_SYNC_START) && (x_cnt <= H_SYNC_END));
        timing_next.vs_n    = !((y_cnt >= V_SYNC_START) && (y_cnt <= V_SYNC_END));
        timing_next.blank_n = vis;
        // Coordinates read zero outside the visible area
        timing_next.col     = vis ? (x_cnt - H_VIS_START) : '0;
        timing_next.row     = vis ? (y_cnt - V_VIS_START) : '0;
    end

    always_ff @(posedge VGA_CLK) begin
        if (i_rst) begin
            o_timing      <= TIMING_IDLE;
            o_frame_start <= 1'b0;
        end else begin
            o_timing      <= timing_next;
            // Lines up with the first registered vsync low cycle
            o_frame_start <= (x_cnt == '0) && (y_cnt == V_SYNC_START);
        end
    end

    // Counters never leave the frame
    a_cnt_range: assert property (@(posedge VGA_CLK) disable iff (i_rst)
        (x_cnt < H_TOTAL) && (y_cnt < V_TOTAL));

endmodule

// File: marker_classify.sv
`timescale 1ns/1ns
// Marker colour classifier
// Flags strongly red visible camera pixels as paddle markers, split into
// left and right halves, and registers them with their timing

module marker_classify
    import pong_pkg::*;
#(
    parameter coord_t SPLIT_COL = 13'd320
) (
    input  logic               VGA_CLK,
    input  logic               i_rst,
    input  timing_t            i_timing,
    input  rgb_t               i_cam_pix,
    input  logic [COLOR_W-1:0] i_threshold,
    output pixel_t             o_pix
);

    logic [COLOR_W-1:0] half_r;
    logic               is_mark;

    // Red above threshold, green and blue well below red
    always_comb begin
        half_r  = i_cam_pix.r >> 1;
        is_mark = i_timing.blank_n
                  && (i_cam_pix.r >= i_threshold)
                  && (i_cam_pix.g < half_r)
                  && (i_cam_pix.b < half_r);
    end

    always_ff @(posedge VGA_CLK) begin
        if (i_rst) begin
            o_pix.tim        <= TIMING_IDLE;
            o_pix.rgb        <= '0;
            o_pix.mark_left  <= 1'b0;
            o_pix.mark_right <= 1'b0;
        end else begin
            o_pix.tim        <= i_timing;
            // Camera data only counts inside the visible area
            o_pix.rgb        <= i_timing.blank_n ? i_cam_pix : '0;
            o_pix.mark_left  <= is_mark && (i_timing.col < SPLIT_COL);
            o_pix.mark_right <= is_mark && (i_timing.col >= SPLIT_COL);
        end
    end

endmodule

// File: paddle_tracker.sv
`timescale 1ns/1ns
// Paddle tracker for one side of the screen
// Gathers the row extent of this side's marker pixels over a frame and
// moves the paddle centre to the middle of that extent at frame start

module paddle_tracker
    import pong_pkg::*;
#(
    parameter bit LEFT = 1'b1
) (
    input  logic   VGA_CLK,
    input  logic   i_rst,
    input  pixel_t i_pix,
    input  logic   i_frame_start,
    output coord_t o_center
);

    localparam coord_t CENTER_INIT = VIS_H >> 1;

    logic             mark;
    logic             seen;
    coord_t           min_row;
    coord_t           max_row;
    logic [COORD_W:0] row_sum;

    assign mark    = LEFT ? i_pix.mark_left : i_pix.mark_right;
    // One extra bit so the sum cannot wrap
    assign row_sum = {1'b0, min_row} + {1'b0, max_row};

    always_ff @(posedge VGA_CLK) begin
        if (i_rst) begin
            seen     <= 1'b0;
            min_row  <= '0;
            max_row  <= '0;
            o_center <= CENTER_INIT;
        end else if (i_frame_start) begin
            // No markers last frame, keep the old centre
            if (seen) begin
                o_center <= row_sum[COORD_W:1];
            end
            seen    <= 1'b0;
            min_row <= '0;
            max_row <= '0;
        end else if (mark) begin
            if (!seen || (i_pix.tim.row < min_row)) begin
                min_row <= i_pix.tim.row;
            end
            if (!seen || (i_pix.tim.row > max_row)) begin
                max_row <= i_pix.tim.row;
            end
            seen <= 1'b1;
        end
    end

    // Extent stays ordered once a marker has been seen
    a_extent_order: assert property (@(posedge VGA_CLK) disable iff (i_rst)
        seen |-> (min_row <= max_row));

endmodule

// File: overlay_render.sv
`timescale 1ns/1ns
// Overlay renderer
// Draws both paddle bars over the camera image and registers the VGA
// sync, blank and colour outputs

module overlay_render
    import pong_pkg::*;
#(
    parameter coord_t PADDLE_W      = 13'd8,
    parameter coord_t PADDLE_HALF_H = 13'd20,
    parameter coord_t PADDLE_MARGIN = 13'd16
) (
    input  logic   VGA_CLK,
    input  logic   i_rst,
    input  pixel_t i_pix,
    input  logic   i_overlay_en,
    input  coord_t i_left_center,
    input  coord_t i_right_center,
    output logic   o_vga_hs_n,
    output logic   o_vga_vs_n,
    output logic   o_vga_blank_n,
    output rgb_t   o_vga_rgb
);

    // Column windows, end exclusive
    localparam coord_t L_START = PADDLE_MARGIN;
    localparam coord_t L_END   = PADDLE_MARGIN + PADDLE_W;
    localparam coord_t R_START = VIS_W - PADDLE_MARGIN - PADDLE_W;
    localparam coord_t R_END   = VIS_W - PADDLE_MARGIN;
    localparam rgb_t   WHITE   = '{r: '1, g: '1, b: '1};

    logic in_left;
    logic in_right;
    rgb_t rgb_next;

    // Row lies less than PADDLE_HALF_H away from the centre
    function automatic logic in_bar_rows(input coord_t row, input coord_t center);
        logic [COORD_W:0] row_w;
        logic [COORD_W:0] ctr_w;
        row_w = {1'b0, row};
        ctr_w = {1'b0, center};
        return ((row_w + PADDLE_HALF_H) > ctr_w) && (row_w < (ctr_w + PADDLE_HALF_H));
    endfunction

    always_comb begin
        in_left  = (i_pix.tim.col >= L_START) && (i_pix.tim.col < L_END)
                   && in_bar_rows(i_pix.tim.row, i_left_center);
        in_right = (i_pix.tim.col >= R_START) && (i_pix.tim.col < R_END)
                   && in_bar_rows(i_pix.tim.row, i_right_center);

        if (!i_pix.tim.blank_n) begin
            rgb_next = '0;
        end else if (i_overlay_en && (in_left || in_right)) begin
            rgb_next = WHITE;
        end else begin
            rgb_next = i_pix.rgb;
        end
    end

    always_ff @(posedge VGA_CLK) begin
        if (i_rst) begin
            o_vga_hs_n    <= 1'b1;
            o_vga_vs_n    <= 1'b1;
            o_vga_blank_n <= 1'b0;
            o_vga_rgb     <= '0;
        end else begin
            o_vga_hs_n    <= i_pix.tim.hs_n;
            o_vga_vs_n    <= i_pix.tim.vs_n;
            o_vga_blank_n <= i_pix.tim.blank_n;
            o_vga_rgb     <= rgb_next;
        end
    end

    // Nothing is driven onto the DAC during blanking
    a_blank_black: assert property (@(posedge VGA_CLK)
        !o_vga_blank_n |-> (o_vga_rgb == '0));

endmodule

// File: pong_vision_top.sv
`timescale 1ns/1ns
// Paddle game video pipeline top level
// Timing generator, marker classifier, two paddle trackers and the
// overlay renderer, two cycles from coordinate to VGA output

module pong_vision_top
    import pong_pkg::*;
#(
    parameter coord_t SPLIT_COL     = 13'd320,
    parameter coord_t PADDLE_W      = 13'd8,
    parameter coord_t PADDLE_HALF_H = 13'd20,
    parameter coord_t PADDLE_MARGIN = 13'd16
) (
    input  logic               VGA_CLK,
    input  logic               i_rst,
    input  rgb_t               i_cam_pix,
    input  logic [COLOR_W-1:0] i_threshold,
    input  logic               i_overlay_en,
    output logic               o_pix_req,
    output logic               o_vga_hs_n,
    output logic               o_vga_vs_n,
    output logic               o_vga_blank_n,
    output rgb_t               o_vga_rgb
);

    timing_t timing;
    logic    frame_start;
    pixel_t  pix;
    coord_t  left_center;
    coord_t  right_center;

    // Camera pixel is taken in the same cycle as the request
    assign o_pix_req = timing.blank_n;

    vga_timing u_vga_timing (
        .VGA_CLK       (VGA_CLK),
        .i_rst         (i_rst),
        .o_timing      (timing),
        .o_frame_start (frame_start)
    );

    marker_classify #(.SPLIT_COL(SPLIT_COL)) u_marker_classify (
        .VGA_CLK     (VGA_CLK),
        .i_rst       (i_rst),
        .i_timing    (timing),
        .i_cam_pix   (i_cam_pix),
        .i_threshold (i_threshold),
        .o_pix       (pix)
    );

    paddle_tracker #(.LEFT(1'b1)) u_left_tracker (
        .VGA_CLK       (VGA_CLK),
        .i_rst         (i_rst),
        .i_pix         (pix),
        .i_frame_start (frame_start),
        .o_center      (left_center)
    );

    paddle_tracker #(.LEFT(1'b0)) u_right_tracker (
        .VGA_CLK       (VGA_CLK),
        .i_rst         (i_rst),
        .i_pix         (pix),
        .i_frame_start (frame_start),
        .o_center      (right_center)
    );

    overlay_render #(
        .PADDLE_W      (PADDLE_W),
        .PADDLE_HALF_H (PADDLE_HALF_H),
        .PADDLE_MARGIN (PADDLE_MARGIN)
    ) u_overlay_render (
        .VGA_CLK        (VGA_CLK),
        .i_rst          (i_rst),
        .i_pix          (pix),
        .i_overlay_en   (i_overlay_en),
        .i_left_center  (left_center),
        .i_right_center (right_center),
        .o_vga_hs_n     (o_vga_hs_n),
        .o_vga_vs_n     (o_vga_vs_n),
        .o_vga_blank_n  (o_vga_blank_n),
        .o_vga_rgb      (o_vga_rgb)
    );

endmodule

// File: tb_pong_vision_top.sv
`timescale 1ns/1ns
// Testbench for the paddle game video pipeline
// Runs its own 800 x 525 frame model, drives a camera pattern per frame
// and checks sync, blank, pixel request and overlay two cycles later

module tb_pong_vision_top
    import pong_pkg::*;
();

    localparam int LINE_LEN     = 800;
    localparam int FRAME_LINES  = 525;
    localparam int FRAME_CYCLES = LINE_LEN * FRAME_LINES;
    localparam int MAX_CYCLES   = 10 * FRAME_CYCLES;
    localparam int SEED         = 12;

    // Expected VGA outputs for one coordinate
    typedef struct packed {
        logic hs_n;
        logic vs_n;
        logic blank_n;
        rgb_t rgb;
    } vga_out_t;

    localparam vga_out_t OUT_IDLE  = '{hs_n: 1'b1, vs_n: 1'b1, blank_n: 1'b0, rgb: '0};
    localparam rgb_t     WHITE_PIX = '{r: 8'd255, g: 8'd255, b: 8'd255};
    localparam rgb_t     RED_PIX   = '{r: 8'd200, g: 8'd0, b: 8'd0};

    logic       VGA_CLK;
    logic       i_rst;
    rgb_t       i_cam_pix;
    logic [7:0] i_threshold;
    logic       i_overlay_en;
    logic       o_pix_req;
    logic       o_vga_hs_n;
    logic       o_vga_vs_n;
    logic       o_vga_blank_n;
    rgb_t       o_vga_rgb;

    int       mx;
    int       my;
    int       n_checks;
    int       n_errors;
    vga_out_t exp_d1;
    vga_out_t exp_d2;

    pong_vision_top u_pong_vision_top (
        .VGA_CLK       (VGA_CLK),
        .i_rst         (i_rst),
        .i_cam_pix     (i_cam_pix),
        .i_threshold   (i_threshold),
        .i_overlay_en  (i_overlay_en),
        .o_pix_req     (o_pix_req),
        .o_vga_hs_n    (o_vga_hs_n),
        .o_vga_vs_n    (o_vga_vs_n),
        .o_vga_blank_n (o_vga_blank_n),
        .o_vga_rgb     (o_vga_rgb)
    );

    initial begin
        VGA_CLK = 1'b0;
        forever #20 VGA_CLK = ~VGA_CLK;
    end

    // Watchdog in case the sequence never reaches its end
    initial begin
        int waited;
        waited = 0;
        while (waited < MAX_CYCLES) begin
            @(posedge VGA_CLK);
            waited++;
        end
        $display("Timeout: cycle limit reached before the directed tests finished");
        $display("Simulation failed");
        $finish;
    end

    // ======================================================================
    // Helpers
    // ======================================================================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        n_checks++;
        if (got !== expected) begin
            n_errors++;
            $display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
                     $time, name, got, expected);
        end
    endtask

    task automatic check_outputs(input vga_out_t expected);
        check_value("o_vga_hs_n", {31'b0, o_vga_hs_n}, {31'b0, expected.hs_n});
        check_value("o_vga_vs_n", {31'b0, o_vga_vs_n}, {31'b0, expected.vs_n});
        check_value("o_vga_blank_n", {31'b0, o_vga_blank_n}, {31'b0, expected.blank_n});
        check_value("o_vga_rgb", {8'b0, o_vga_rgb}, {8'b0, expected.rgb});
    endtask

    function automatic logic in_range(input int v, input int lo, input int hi);
        return (v >= lo) && (v <= hi);
    endfunction

    // Bar is 8 columns wide, rows closer than 20 to its centre
    function automatic logic bar_hit(input int col, input int row, input int start,
                                     input int center);
        return in_range(col, start, start + 7) && (row - center > -20) && (row - center < 20);
    endfunction

    // Pattern 1 left block, 2 right block, 3 both sides at other rows
    function automatic logic block_hit(input int pattern, input int col, input int row);
        case (pattern)
            1: return in_range(col, 100, 139) && in_range(row, 100, 139);
            2: return in_range(col, 500, 539) && in_range(row, 300, 349);
            3: return (in_range(col, 100, 139) && in_range(row, 200, 259))
                      || (in_range(col, 500, 539) && in_range(row, 50, 89));
            default: return 1'b0;
        endcase
    endfunction

    // Dim grey background, never a marker
    function automatic rgb_t cam_pattern(input int pattern, input logic vis,
                                         input int col, input int row);
        logic [7:0] grey;
        grey = 8'($urandom % 64);
        if (vis && block_hit(pattern, col, row)) begin
            return RED_PIX;
        end
        return '{r: grey, g: grey, b: grey};
    endfunction

    // One pixel slot: check the output of two slots back, drive this one
    task automatic advance_pixel(input int pattern, input logic ovl, input logic [7:0] thr,
                                 input int lc, input int rc);
        logic     vis;
        int       col;
        int       row;
        rgb_t     pix;
        vga_out_t nxt;
        @(negedge VGA_CLK);
        check_outputs(exp_d2);
        vis = (mx >= 160) && (my >= 45);
        check_value("o_pix_req", {31'b0, o_pix_req}, {31'b0, vis});
        col = vis ? mx - 160 : 0;
        row = vis ? my - 45 : 0;
        pix = cam_pattern(pattern, vis, col, row);
        i_cam_pix    = pix;
        i_overlay_en = ovl;
        i_threshold  = thr;
        nxt.hs_n    = !in_range(mx, 2, 97);
        nxt.vs_n    = !in_range(my, 13, 14);
        nxt.blank_n = vis;
        if (!vis) begin
            nxt.rgb = '0;
        end else if (ovl && (bar_hit(col, row, 16, lc) || bar_hit(col, row, 616, rc))) begin
            nxt.rgb = WHITE_PIX;
        end else begin
            nxt.rgb = pix;
        end
        exp_d2 = exp_d1;
        exp_d1 = nxt;
        if (mx == LINE_LEN - 1) begin
            mx = 0;
            my = (my == FRAME_LINES - 1) ? 0 : my + 1;
        end else begin
            mx++;
        end
    endtask

    // Bar centres are the ones expected while this frame is drawn
    task automatic run_frame(input int pattern, input logic ovl, input logic [7:0] thr,
                             input int lc, input int rc);
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            advance_pixel(pattern, ovl, thr, lc, rc);
        end
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic test_reset_state();
        for (int i = 0; i < 10; i++) begin
            @(negedge VGA_CLK);
            check_outputs(OUT_IDLE);
            check_value("o_pix_req", {31'b0, o_pix_req}, 32'd0);
        end
        i_rst = 1'b0;
    endtask

    task automatic test_sync_passthrough();
        run_frame(0, 1'b0, 8'd128, 240, 240);
    endtask

    task automatic test_left_tracking();
        run_frame(1, 1'b1, 8'd128, 240, 240);
        // Rows 100 to 139 give a centre of 119
        run_frame(0, 1'b1, 8'd128, 119, 240);
    endtask

    task automatic test_right_tracking_hold();
        run_frame(2, 1'b1, 8'd128, 119, 240);
        run_frame(0, 1'b1, 8'd128, 119, 324);
        // Empty frame, both centres hold
        run_frame(0, 1'b1, 8'd128, 119, 324);
    endtask

    task automatic test_threshold();
        // Red of 200 sits below a threshold of 220
        run_frame(3, 1'b1, 8'd220, 119, 324);
        run_frame(0, 1'b1, 8'd220, 119, 324);
    endtask

    initial begin
        void'($urandom(SEED));
        i_rst        = 1'b1;
        i_cam_pix    = '0;
        i_threshold  = 8'd128;
        i_overlay_en = 1'b0;
        mx           = 0;
        my           = 0;
        n_checks     = 0;
        n_errors     = 0;
        exp_d1       = OUT_IDLE;
        exp_d2       = OUT_IDLE;
        test_reset_state();
        test_sync_passthrough();
        test_left_tracking();
        test_right_tracking_hold();
        test_threshold();
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: pong_vision_top.f
pong_pkg.sv
vga_timing.sv
marker_classify.sv
paddle_tracker.sv
overlay_render.sv
pong_vision_top.sv
tb_pong_vision_top.sv

// File: Makefile
# Verilator build and run for the paddle game video pipeline

VERILATOR ?= verilator
TOP       ?= tb_pong_vision_top
FILELIST  ?= pong_vision_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
